/* rtl/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

    localparam int CP0_WORD_W = 32;
    localparam int HW_INT_NUM = 6;

    // Register numbers that this CP0 implements
    typedef enum logic [4:0] {
        CP0_REG_BADVADDR = 5'd8,
        CP0_REG_COUNT    = 5'd9,
        CP0_REG_COMPARE  = 5'd11,
        CP0_REG_STATUS   = 5'd12,
        CP0_REG_CAUSE    = 5'd13,
        CP0_REG_EPC      = 5'd14,
        CP0_REG_PRID     = 5'd15,
        CP0_REG_CONFIG   = 5'd16
    } cp0Addr_e;

    // Exception kinds as reported by the memory stage
    typedef enum logic [4:0] {
        EXC_NONE,
        EXC_INTERRUPT,
        EXC_TLB_MODIFIED,
        EXC_TLB_REFILL_IF,
        EXC_TLB_INVALID_IF,
        EXC_RD_TLB_REFILL_MEM,
        EXC_RD_TLB_INVALID_MEM,
        EXC_WR_TLB_REFILL_MEM,
        EXC_WR_TLB_INVALID_MEM,
        EXC_WRONG_ADDR_IF,
        EXC_RD_WRONG_ADDR_MEM,
        EXC_WR_WRONG_ADDR_MEM,
        EXC_SYSCALL,
        EXC_BREAK,
        EXC_RESERVED_INSTR,
        EXC_CPU,
        EXC_OVERFLOW,
        EXC_TRAP,
        EXC_ERET,
        EXC_REFETCH
    } excType_e;

    // Architectural Cause.ExcCode values
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_MOD  = 5'd1,
        CODE_TLBL = 5'd2,
        CODE_TLBS = 5'd3,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_CPU  = 5'd11,
        CODE_OV   = 5'd12,
        CODE_TR   = 5'd13
    } excCode_e;

    // One MTC0 request
    typedef struct packed {
        logic                  en;
        cp0Addr_e              addr;
        logic [2:0]            sel;
        logic [CP0_WORD_W-1:0] data;
    } cp0Write_t;

    typedef struct packed {
        excType_e              excType;
        logic [CP0_WORD_W-1:0] pc;
        logic                  inDelaySlot;
        logic [CP0_WORD_W-1:0] badAddr;   // Memory stage address
    } excReport_t;

    // Fields the exception detection logic looks at
    typedef struct packed {
        logic                  bev;
        logic [7:0]            im;
        logic                  exl;
        logic                  ie;
        logic [HW_INT_NUM-1:0] ipHw;
        logic [1:0]            ipSw;
        logic [CP0_WORD_W-1:0] epc;
        logic [2:0]            k0;
    } statusView_t;

endpackage

`default_nettype wire

/* rtl/cp0Timer.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0Timer (
    input  logic                            clk,
    input  logic                            arstN,
    input  cp0Pkg::cp0Write_t               wr,
    output logic [cp0Pkg::CP0_WORD_W-1:0]   count,
    output logic [cp0Pkg::CP0_WORD_W-1:0]   compare,
    output logic                            timerIrq
);
    import cp0Pkg::*;

    logic tickPhase;   // Count advances every second edge
    logic countWr;
    logic compareWr;
    logic countMatch;

    assign countWr    = wr.en && (wr.addr == CP0_REG_COUNT);
    assign compareWr  = wr.en && (wr.addr == CP0_REG_COMPARE);
    assign countMatch = (count == compare);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tickPhase <= 1'b0;
            count     <= '0;
        end else if (countWr) begin
            tickPhase <= 1'b0;   // Restart the half-rate phase
            count     <= wr.data;
        end else begin
            tickPhase <= ~tickPhase;
            if (tickPhase) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            compare <= '0;
        end else if (compareWr) begin
            compare <= wr.data;
        end
    end

    // Sticky flag, Compare write acknowledges it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            timerIrq <= 1'b0;
        end else if (compareWr) begin
            timerIrq <= 1'b0;
        end else if (countMatch) begin
            timerIrq <= 1'b1;
        end
    end

    irqAfterMatch : assert property (
        @(posedge clk) disable iff (!arstN)
        $rose(timerIrq) |-> $past(countMatch)
    ) else $error("timerIrq rose without a Count/Compare match");

endmodule

`default_nettype wire

/* rtl/cp0ControlRegs.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0ControlRegs #(
    parameter logic [2:0] K0_RESET = 3'd3
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  cp0Pkg::cp0Write_t               wr,
    input  logic [cp0Pkg::HW_INT_NUM-1:0]   hwInt,
    input  logic                            timerIrq,
    output logic                            bev,
    output logic                            ie,
    output logic [7:0]                      im,
    output logic [cp0Pkg::HW_INT_NUM-1:0]   ipHw,
    output logic [1:0]                      ipSw,
    output logic [2:0]                      k0
);
    import cp0Pkg::*;

    logic                  statusWr;
    logic                  causeWr;
    logic                  configWr;
    logic [HW_INT_NUM-1:0] intPending;

    assign statusWr = wr.en && (wr.addr == CP0_REG_STATUS);
    assign causeWr  = wr.en && (wr.addr == CP0_REG_CAUSE);
    assign configWr = wr.en && (wr.addr == CP0_REG_CONFIG) && (wr.sel == 3'd0);

    // Timer shares the top hardware line (IP7)
    assign intPending = hwInt | {timerIrq, {(HW_INT_NUM - 1){1'b0}}};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bev <= 1'b1;   // Boot vectors after reset
            im  <= '0;
            ie  <= 1'b0;
        end else if (statusWr) begin
            bev <= wr.data[22];
            im  <= wr.data[15:8];
            ie  <= wr.data[0];
        end
    end

    // Software interrupt requests
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ipSw <= '0;
        end else if (causeWr) begin
            ipSw <= wr.data[9:8];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ipHw <= '0;
        end else begin
            ipHw <= intPending;   // One cycle sampling delay
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            k0 <= K0_RESET;
        end else if (configWr) begin
            k0 <= wr.data[2:0];
        end
    end

    wrAddrKnown : assert property (
        @(posedge clk) disable iff (!arstN)
        wr.en |-> !$isunknown(wr.addr)
    ) else $error("CP0 write with unknown address");

endmodule

`default_nettype wire

/* rtl/cp0ExcRecorder.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0ExcRecorder (
    input  logic                            clk,
    input  logic                            arstN,
    input  cp0Pkg::cp0Write_t               wr,
    input  cp0Pkg::excReport_t              exc,
    output logic                            exl,
    output logic                            bd,
    output cp0Pkg::excCode_e                excCode,
    output logic [cp0Pkg::CP0_WORD_W-1:0]   epc,
    output logic [cp0Pkg::CP0_WORD_W-1:0]   badVAddr
);
    import cp0Pkg::*;

    logic excValid;   // Anything but None and Refetch
    logic excTaken;   // A real exception, ERET excluded
    logic fetchFault;
    logic memFault;
    logic statusWr;
    logic epcWr;

    // Cause code for a report, other kinds keep the old value
    function automatic excCode_e codeOf(input excType_e t, input excCode_e cur);
        case (t)
            EXC_INTERRUPT:          codeOf = CODE_INT;
            EXC_TLB_MODIFIED:       codeOf = CODE_MOD;
            EXC_TLB_REFILL_IF,
            EXC_TLB_INVALID_IF,
            EXC_RD_TLB_REFILL_MEM,
            EXC_RD_TLB_INVALID_MEM: codeOf = CODE_TLBL;
            EXC_WR_TLB_REFILL_MEM,
            EXC_WR_TLB_INVALID_MEM: codeOf = CODE_TLBS;
            EXC_WRONG_ADDR_IF,
            EXC_RD_WRONG_ADDR_MEM:  codeOf = CODE_ADEL;
            EXC_WR_WRONG_ADDR_MEM:  codeOf = CODE_ADES;
            EXC_SYSCALL:            codeOf = CODE_SYS;
            EXC_BREAK:              codeOf = CODE_BP;
            EXC_RESERVED_INSTR:     codeOf = CODE_RI;
            EXC_CPU:                codeOf = CODE_CPU;
            EXC_OVERFLOW:           codeOf = CODE_OV;
            EXC_TRAP:               codeOf = CODE_TR;
            default:                codeOf = cur;
        endcase
    endfunction

    assign excValid = (exc.excType != EXC_NONE) && (exc.excType != EXC_REFETCH);
    assign excTaken = excValid && (exc.excType != EXC_ERET);
    assign statusWr = wr.en && (wr.addr == CP0_REG_STATUS);
    assign epcWr    = wr.en && (wr.addr == CP0_REG_EPC);

    assign fetchFault = (exc.excType inside {EXC_WRONG_ADDR_IF, EXC_TLB_REFILL_IF,
                                             EXC_TLB_INVALID_IF});
    assign memFault   = (exc.excType inside {EXC_RD_WRONG_ADDR_MEM, EXC_WR_WRONG_ADDR_MEM,
                                             EXC_TLB_MODIFIED, EXC_RD_TLB_REFILL_MEM,
                                             EXC_RD_TLB_INVALID_MEM, EXC_WR_TLB_REFILL_MEM,
                                             EXC_WR_TLB_INVALID_MEM});

    // Report beats MTC0 to Status
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exl <= 1'b0;
        end else if (excValid) begin
            exl <= (exc.excType != EXC_ERET);
        end else if (statusWr) begin
            exl <= wr.data[1];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bd <= 1'b0;
        end else if (excTaken && !exl) begin
            bd <= exc.inDelaySlot;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            excCode <= CODE_INT;
        end else begin
            excCode <= codeOf(exc.excType, excCode);
        end
    end

    // Nested exceptions keep the first return address
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            epc <= '0;
        end else if (excTaken && !exl) begin
            epc <= exc.inDelaySlot ? exc.pc - 32'd4 : exc.pc;
        end else if (!excValid && epcWr) begin
            epc <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            badVAddr <= '0;
        end else if (fetchFault) begin
            badVAddr <= exc.pc;
        end else if (memFault) begin
            badVAddr <= exc.badAddr;
        end
    end

    excTypeKnown : assert property (
        @(posedge clk) disable iff (!arstN)
        !$isunknown(exc.excType)
    ) else $error("Exception type is unknown");

endmodule

`default_nettype wire

/* rtl/cp0ReadMux.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0ReadMux #(
    parameter logic [cp0Pkg::CP0_WORD_W-1:0] PRID_VALUE = 32'h00004220
) (
    input  cp0Pkg::cp0Addr_e                rdAddr,
    input  logic [2:0]                      rdSel,
    input  logic [cp0Pkg::CP0_WORD_W-1:0]   count,
    input  logic [cp0Pkg::CP0_WORD_W-1:0]   compare,
    input  logic                            timerIrq,
    input  logic                            bev,
    input  logic                            ie,
    input  logic [7:0]                      im,
    input  logic [cp0Pkg::HW_INT_NUM-1:0]   ipHw,
    input  logic [1:0]                      ipSw,
    input  logic [2:0]                      k0,
    input  logic                            exl,
    input  logic                            bd,
    input  cp0Pkg::excCode_e                excCode,
    input  logic [cp0Pkg::CP0_WORD_W-1:0]   epc,
    input  logic [cp0Pkg::CP0_WORD_W-1:0]   badVAddr,
    output logic [cp0Pkg::CP0_WORD_W-1:0]   rdData
);
    import cp0Pkg::*;

    logic [CP0_WORD_W-1:0] statusImg;
    logic [CP0_WORD_W-1:0] causeImg;
    logic [CP0_WORD_W-1:0] configImg;

    assign statusImg = {9'b0, bev, 6'b0, im, 6'b0, exl, ie};
    assign causeImg  = {bd, timerIrq, 14'b0, ipHw, ipSw, 1'b0, excCode, 2'b0};

    // M set, MMU type 1 is the standard TLB
    assign configImg = {1'b1, 21'b0, 3'b001, 4'b0, k0};

    always_comb begin
        rdData = '0;
        if (rdSel == 3'd0) begin   // Only select 0 exists here
            case (rdAddr)
                CP0_REG_BADVADDR: rdData = badVAddr;
                CP0_REG_COUNT:    rdData = count;
                CP0_REG_COMPARE:  rdData = compare;
                CP0_REG_STATUS:   rdData = statusImg;
                CP0_REG_CAUSE:    rdData = causeImg;
                CP0_REG_EPC:      rdData = epc;
                CP0_REG_PRID:     rdData = PRID_VALUE;
                CP0_REG_CONFIG:   rdData = configImg;
                default:          rdData = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/cp0Top.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0Top #(
    parameter logic [cp0Pkg::CP0_WORD_W-1:0] PRID_VALUE = 32'h00004220,
    parameter logic [2:0]                    K0_RESET   = 3'd3
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [cp0Pkg::HW_INT_NUM-1:0]   hwInt,
    input  cp0Pkg::cp0Write_t               wr,
    input  cp0Pkg::excReport_t              exc,
    input  cp0Pkg::cp0Addr_e                rdAddr,
    input  logic [2:0]                      rdSel,
    output logic [cp0Pkg::CP0_WORD_W-1:0]   rdData,
    output cp0Pkg::statusView_t             statusView
);
    import cp0Pkg::*;

    logic [CP0_WORD_W-1:0] count;
    logic [CP0_WORD_W-1:0] compare;
    logic                  timerIrq;
    logic                  bev;
    logic                  ie;
    logic [7:0]            im;
    logic [HW_INT_NUM-1:0] ipHw;
    logic [1:0]            ipSw;
    logic [2:0]            k0;
    logic                  exl;
    logic                  bd;
    excCode_e              excCode;
    logic [CP0_WORD_W-1:0] epc;
    logic [CP0_WORD_W-1:0] badVAddr;

    cp0Timer timer_inst (
        .clk      (clk),
        .arstN    (arstN),
        .wr       (wr),
        .count    (count),
        .compare  (compare),
        .timerIrq (timerIrq)
    );

    cp0ControlRegs #(
        .K0_RESET (K0_RESET)
    ) controlRegs_inst (
        .clk      (clk),
        .arstN    (arstN),
        .wr       (wr),
        .hwInt    (hwInt),
        .timerIrq (timerIrq),
        .bev      (bev),
        .ie       (ie),
        .im       (im),
        .ipHw     (ipHw),
        .ipSw     (ipSw),
        .k0       (k0)
    );

    cp0ExcRecorder excRecorder_inst (
        .clk      (clk),
        .arstN    (arstN),
        .wr       (wr),
        .exc      (exc),
        .exl      (exl),
        .bd       (bd),
        .excCode  (excCode),
        .epc      (epc),
        .badVAddr (badVAddr)
    );

    cp0ReadMux #(
        .PRID_VALUE (PRID_VALUE)
    ) readMux_inst (
        .rdAddr   (rdAddr),
        .rdSel    (rdSel),
        .count    (count),
        .compare  (compare),
        .timerIrq (timerIrq),
        .bev      (bev),
        .ie       (ie),
        .im       (im),
        .ipHw     (ipHw),
        .ipSw     (ipSw),
        .k0       (k0),
        .exl      (exl),
        .bd       (bd),
        .excCode  (excCode),
        .epc      (epc),
        .badVAddr (badVAddr),
        .rdData   (rdData)
    );

    // Live fields for the exception detection stage
    always_comb begin
        statusView.bev  = bev;
        statusView.im   = im;
        statusView.exl  = exl;
        statusView.ie   = ie;
        statusView.ipHw = ipHw;
        statusView.ipSw = ipSw;
        statusView.epc  = epc;
        statusView.k0   = k0;
    end

endmodule

`default_nettype wire

/* verif/cp0Tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cp0Tb;
    import cp0Pkg::*;

    localparam logic [31:0] PRID_VALUE   = 32'h00004220;
    localparam logic [2:0]  K0_RESET     = 3'd3;
    localparam int          CLK_PERIOD   = 100;
    localparam int          WR_ROUNDS    = 8;
    localparam int          TIMER_ROUNDS = 3;
    localparam int          TIMER_SPAN   = 6;
    localparam int          EXC_ROUNDS   = 10;
    localparam int          INT_ROUNDS   = 10;
    localparam int          TEST_CYCLES  = 9 + WR_ROUNDS * 10 + 2
                                           + TIMER_ROUNDS * (2 * TIMER_SPAN + 10)
                                           + 1 + EXC_ROUNDS * 20 + INT_ROUNDS * 2 + 12;
    localparam int          WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 2 + 20;

    localparam logic [31:0] CONFIG_FIXED = 32'h8000_0080;   // M bit, MT = 1 (standard TLB)

    logic                  clk;
    logic                  arstN;
    logic [HW_INT_NUM-1:0] hwInt;
    cp0Write_t             wr;
    excReport_t            exc;
    cp0Addr_e              rdAddr;
    logic [2:0]            rdSel;
    logic [CP0_WORD_W-1:0] rdData;
    statusView_t           statusView;

    // Read expectation, holds from the edge where it is driven
    logic        chkRd;
    logic [31:0] expData;
    logic [31:0] expMask;
    statusView_t expView;
    statusView_t viewMask;

    // Expected exception state
    logic        expExl;
    logic        expBd;
    logic [4:0]  expCode;
    logic [31:0] expEpc;
    logic [31:0] expBadV;

    cp0Top #(
        .PRID_VALUE (PRID_VALUE),
        .K0_RESET   (K0_RESET)
    ) cp0Top_inst (
        .clk        (clk),
        .arstN      (arstN),
        .hwInt      (hwInt),
        .wr         (wr),
        .exc        (exc),
        .rdAddr     (rdAddr),
        .rdSel      (rdSel),
        .rdData     (rdData),
        .statusView (statusView)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic reportMismatch(input string what);
        $display("FAILED at time %0t: %s", $time, what);
        $display("Verification failed");
        $fatal(1, "Check failed");
    endtask

    // Architectural ExcCode per report kind
    function automatic logic [4:0] causeCodeFor(input excType_e t, input logic [4:0] prev);
        case (t)
            EXC_INTERRUPT:          return 5'd0;
            EXC_TLB_MODIFIED:       return 5'd1;
            EXC_TLB_REFILL_IF,
            EXC_TLB_INVALID_IF,
            EXC_RD_TLB_REFILL_MEM,
            EXC_RD_TLB_INVALID_MEM: return 5'd2;    // TLBL
            EXC_WR_TLB_REFILL_MEM,
            EXC_WR_TLB_INVALID_MEM: return 5'd3;    // TLBS
            EXC_WRONG_ADDR_IF,
            EXC_RD_WRONG_ADDR_MEM:  return 5'd4;    // AdEL
            EXC_WR_WRONG_ADDR_MEM:  return 5'd5;
            EXC_SYSCALL:            return 5'd8;
            EXC_BREAK:              return 5'd9;
            EXC_RESERVED_INSTR:     return 5'd10;
            EXC_CPU:                return 5'd11;
            EXC_OVERFLOW:           return 5'd12;
            EXC_TRAP:               return 5'd13;
            default:                return prev;    // ERET and Refetch
        endcase
    endfunction

    // Fetch faults report the PC, memory faults the data address
    function automatic logic [31:0] faultAddress(input excType_e t, input logic [31:0] pc,
                                                 input logic [31:0] bad, input logic [31:0] prev);
        case (t)
            EXC_WRONG_ADDR_IF, EXC_TLB_REFILL_IF, EXC_TLB_INVALID_IF: return pc;
            EXC_RD_WRONG_ADDR_MEM, EXC_WR_WRONG_ADDR_MEM, EXC_TLB_MODIFIED,
            EXC_RD_TLB_REFILL_MEM, EXC_RD_TLB_INVALID_MEM,
            EXC_WR_TLB_REFILL_MEM, EXC_WR_TLB_INVALID_MEM:            return bad;
            default:                                                  return prev;
        endcase
    endfunction

    task automatic writeReg(input cp0Addr_e addr, input logic [2:0] sel, input logic [31:0] data);
        wr.en   <= 1'b1;
        wr.addr <= addr;
        wr.sel  <= sel;
        wr.data <= data;
        chkRd   <= 1'b0;
        @(posedge clk);   // Captured here
        wr.en <= 1'b0;
    endtask

    task automatic expectRead(input cp0Addr_e addr, input logic [31:0] data,
                              input logic [31:0] mask);
        rdAddr  <= addr;
        rdSel   <= 3'd0;
        expData <= data & mask;
        expMask <= mask;
        chkRd   <= 1'b1;
        @(posedge clk);
    endtask

    task automatic resetImageReads();
        expectRead(CP0_REG_CAUSE, 32'h0, '1);   // Before the first Count/Compare match
        expectRead(CP0_REG_STATUS, 32'h0040_0000, '1);
        expectRead(CP0_REG_PRID, PRID_VALUE, '1);
        expectRead(CP0_REG_CONFIG, CONFIG_FIXED | {29'b0, K0_RESET}, '1);
    endtask

    task automatic writeReadbackRounds();
        logic [31:0] d;
        writeReg(CP0_REG_COMPARE, 3'd0, 32'hFFFF_FFFF);   // Park the timer far away
        @(posedge clk);
        for (int i = 0; i < WR_ROUNDS; i++) begin
            d = $urandom;
            writeReg(CP0_REG_STATUS, 3'd0, d);
            expView.bev <= d[22];
            expView.im  <= d[15:8];
            expView.exl <= d[1];
            expView.ie  <= d[0];
            expectRead(CP0_REG_STATUS, d & 32'h0040_FF03, '1);
            d = $urandom;
            writeReg(CP0_REG_CAUSE, 3'd0, d);
            expView.ipSw <= d[9:8];
            expectRead(CP0_REG_CAUSE, d & 32'h0000_0300, '1);
            d = $urandom;
            writeReg(CP0_REG_EPC, 3'd0, d);
            expView.epc <= d;
            expEpc = d;
            expectRead(CP0_REG_EPC, d, '1);
            d = $urandom;
            writeReg(CP0_REG_CONFIG, 3'd0, d);
            expView.k0 <= d[2:0];
            expectRead(CP0_REG_CONFIG, CONFIG_FIXED | {29'b0, d[2:0]}, '1);
            writeReg(CP0_REG_PRID, 3'd0, $urandom);   // Read-only
            expectRead(CP0_REG_PRID, PRID_VALUE, '1);
        end
    endtask

    task automatic timerCountAndIrq();
        logic [31:0] n;
        int          k;
        for (int r = 0; r < TIMER_ROUNDS; r++) begin
            n = $urandom;
            k = 1 + int'($urandom % TIMER_SPAN);
            writeReg(CP0_REG_COMPARE, 3'd0, n + k);
            writeReg(CP0_REG_COUNT, 3'd0, n);
            for (int j = 0; j <= 2 * k; j++) begin
                expectRead(CP0_REG_COUNT, n + j / 2, '1);   // Half rate
            end
            expectRead(CP0_REG_CAUSE, 32'h4000_0000, 32'h4000_0000);
            expectRead(CP0_REG_CAUSE, 32'h4000_8000, 32'h4000_FC00);   // IP7 one cycle later
            writeReg(CP0_REG_COMPARE, 3'd0, n);
            expectRead(CP0_REG_CAUSE, 32'h0, 32'h4000_0000);
            expectRead(CP0_REG_CAUSE, 32'h0, 32'h4000_FC00);
        end
    endtask

    task automatic raiseAndCheck(input excType_e t);
        logic [31:0] pc;
        logic [31:0] bad;
        logic        ds;
        pc  = $urandom;
        bad = $urandom;
        ds  = 1'($urandom % 2);
        expCode = causeCodeFor(t, expCode);
        expBadV = faultAddress(t, pc, bad, expBadV);
        if (t == EXC_ERET) begin
            expExl = 1'b0;
        end else if (t != EXC_REFETCH) begin
            if (!expExl) begin
                expBd  = ds;
                expEpc = ds ? pc - 32'd4 : pc;   // Return to the branch
            end
            expExl = 1'b1;
        end
        exc.excType     <= t;
        exc.pc          <= pc;
        exc.inDelaySlot <= ds;
        exc.badAddr     <= bad;
        @(posedge clk);
        exc.excType <= EXC_NONE;
        expView.exl <= expExl;
        expView.epc <= expEpc;
        expectRead(CP0_REG_CAUSE, {expBd, 24'b0, expCode, 2'b0}, 32'h8000_007C);
        expectRead(CP0_REG_EPC, expEpc, '1);
        expectRead(CP0_REG_BADVADDR, expBadV, '1);
        expectRead(CP0_REG_STATUS, {30'b0, expExl, 1'b0}, 32'h0000_0002);
    endtask

    task automatic exceptionSequences();
        writeReg(CP0_REG_STATUS, 3'd0, 32'h0);
        expView.bev <= 1'b0;
        expView.im  <= '0;
        expView.exl <= 1'b0;
        expView.ie  <= 1'b0;
        expExl = 1'b0;
        for (int r = 0; r < EXC_ROUNDS; r++) begin
            raiseAndCheck(excType_e'(5'(1 + $urandom % 17)));
            raiseAndCheck(excType_e'(5'(1 + $urandom % 17)));   // Nested, EPC holds
            raiseAndCheck(EXC_ERET);
            raiseAndCheck(EXC_REFETCH);
        end
    endtask

    task automatic interruptSampling();
        logic [5:0]  h;
        logic [31:0] m;
        expView.ipHw  <= '0;
        viewMask.ipHw <= '1;
        for (int i = 0; i < INT_ROUNDS; i++) begin
            h = 6'($urandom);
            hwInt <= h;
            @(posedge clk);   // Sampled on this edge
            expView.ipHw <= h;
            expectRead(CP0_REG_CAUSE, {16'b0, h, 10'b0}, 32'h0000_FC00);
        end
        // Timer flag joins the top line
        h = 6'($urandom) & 6'h1F;
        m = $urandom;
        hwInt <= h;
        writeReg(CP0_REG_COMPARE, 3'd0, m);
        expView.ipHw <= h;
        writeReg(CP0_REG_COUNT, 3'd0, m);
        repeat (2) @(posedge clk);
        expView.ipHw <= h | 6'h20;
        expectRead(CP0_REG_CAUSE, {2'b01, 14'b0, h | 6'h20, 10'b0}, 32'h4000_FC00);
        writeReg(CP0_REG_COMPARE, 3'd0, m - 32'd1);
        @(posedge clk);
        expView.ipHw <= h;
        expectRead(CP0_REG_CAUSE, {16'b0, h, 10'b0}, 32'h4000_FC00);
    endtask

    initial begin
        void'($urandom(32'ha669));
        arstN         = 1'b0;
        hwInt         = '0;
        wr            = '0;
        exc           = '0;
        rdAddr        = CP0_REG_STATUS;
        rdSel         = 3'd0;
        chkRd         = 1'b0;
        expData       = '0;
        expMask       = '0;
        expView       = '0;
        expView.bev   = 1'b1;
        expView.k0    = K0_RESET;
        viewMask      = '1;
        viewMask.ipHw = '0;   // Timer match right after reset
        expExl        = 1'b0;
        expBd         = 1'b0;
        expCode       = 5'd0;
        expEpc        = '0;
        expBadV       = '0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        resetImageReads();
        writeReadbackRounds();
        timerCountAndIrq();
        exceptionSequences();
        interruptSampling();
        @(posedge clk);
        $display("Verification passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1, "Simulation timed out");
    end

    readMatches : assert property (
        @(posedge clk) disable iff (!arstN)
        chkRd |-> ((rdData & expMask) == expData)
    ) else reportMismatch($sformatf("register %0d read %h, expected %h under mask %h",
                                    $sampled(rdAddr), $sampled(rdData), $sampled(expData),
                                    $sampled(expMask)));

    viewMatches : assert property (
        @(posedge clk) disable iff (!arstN)
        (statusView & viewMask) == (expView & viewMask)
    ) else reportMismatch($sformatf("statusView %h, expected %h under mask %h",
                                    $sampled(statusView), $sampled(expView),
                                    $sampled(viewMask)));

endmodule

`default_nettype wire

/* vlog.f */
rtl/cp0Pkg.sv
rtl/cp0Timer.sv
rtl/cp0ControlRegs.sv
rtl/cp0ExcRecorder.sv
rtl/cp0ReadMux.sv
rtl/cp0Top.sv
verif/cp0Tb.sv

/* Bender.yml */
package:
  name: cp0

sources:
  - rtl/cp0Pkg.sv
  - rtl/cp0Timer.sv
  - rtl/cp0ControlRegs.sv
  - rtl/cp0ExcRecorder.sv
  - rtl/cp0ReadMux.sv
  - rtl/cp0Top.sv
  - target: test
    files:
      - verif/cp0Tb.sv
